// ==== bench/mmv_master_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmv_master_model #(
    parameter int          N_REQ  = 600,          // Requests per run
    parameter int          MAX_RD = 6,            // Outstanding read cap
    parameter logic [31:0] SEED   = 32'd77675
) (
    input  wire                clk,
    input  wire                reset,
    input  wire                start,             // Level, traffic runs while high
    input  wire                busy,
    input  wire                rval,
    output mmv_pkg::mm_req_t   mm_req,
    output logic               wreq,
    output logic               rreq,
    output logic               done,              // All N_REQ requests accepted
    output int                 n_sent,
    output int                 outstanding
);
    import mmv_pkg::*;

    localparam mm_addr_t WIN_BASE = 10'h200;      // 32-word traffic window

    logic [31:0] lfsr_state;
    mm_addr_t    rd_q [$];                        // Outstanding reads, oldest first
    logic        taken;                           // Held request goes in at next edge

    // ----------------------------------------------------------
    // Random source
    // ----------------------------------------------------------

    // Fibonacci form, x^32+x^22+x^2+x^1+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // New slot: idle, write or read
    task automatic next_request();
        logic [31:0] kind;
        logic [31:0] offs;
        logic [31:0] dat;
        logic        is_wr;
        take_bits(3, kind);
        take_bits(5, offs);
        take_bits(32, dat);
        is_wr = kind[0] || (rd_q.size() >= MAX_RD);   // Too many reads, write instead
        if (kind == 32'd7) begin
            wreq = 1'b0;                          // Idle slot, 1 in 8
            rreq = 1'b0;
        end else begin
            mm_req = '{we: is_wr, addr: WIN_BASE + mm_addr_t'(offs[4:0]), wdat: dat};
            wreq   = is_wr;
            rreq   = ~is_wr;
        end
    endtask

    initial begin
        mm_req      = '0;
        wreq        = 1'b0;
        rreq        = 1'b0;
        done        = 1'b0;
        n_sent      = 0;
        outstanding = 0;
        lfsr_state  = SEED;
        taken       = 1'b0;
    end

    // ----------------------------------------------------------
    // Drive on the falling edge, busy and rval are stable here
    // ----------------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            taken = 1'b0;
        end else begin
            if (rval && rd_q.size() > 0) rd_q.delete(0);   // Oldest read came back

            // Request held last cycle went in on the rising edge
            if (taken) begin
                n_sent++;
                if (rreq) rd_q.push_back(mm_req.addr);
            end

            if (start && n_sent < N_REQ && (taken || !(wreq || rreq))) begin
                next_request();
            end else if (taken) begin
                wreq = 1'b0;
                rreq = 1'b0;
            end

            taken       = (wreq || rreq) && !busy;   // Busy holds the request
            outstanding = rd_q.size();
            done        = (n_sent >= N_REQ) && !(wreq || rreq);
        end
    end

endmodule : mmv_master_model

`default_nettype wire

// ==== bench/tb_mmv_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmv_defs.svh"

module tb_mmv_subsys;
    import mmv_pkg::*;

    localparam int N_RANDOM = 600;
    // Worst case per request is MMV_MAX_WAIT+3 cycles, plus idle slots and directed traffic
    localparam int TIMEOUT_CYCLES = (N_RANDOM + 50) * (`MMV_MAX_WAIT + 3);

    typedef struct packed {
        mm_addr_t addr;
        mm_data_t exp;                            // Expected word at acceptance
        logic     known;                          // Address written before the read
    } rd_entry_t;

    logic     clk;
    logic     reset;
    mm_req_t  d_req;                              // Directed stimulus
    logic     d_wreq;
    logic     d_rreq;
    logic     use_master;
    logic     m_start;
    mm_req_t  m_req;
    logic     m_wreq;
    logic     m_rreq;
    logic     m_done;
    int       m_sent;
    int       m_outstanding;
    mm_req_t  mm_req;
    logic     wreq;
    logic     rreq;
    logic     busy;
    logic     rval;
    mm_data_t rdat;

    mm_data_t  shadow  [`MMV_MEM_DEPTH];          // Reference memory
    logic      written [`MMV_MEM_DEPTH];
    rd_entry_t rd_q [$];
    int        cycle_cnt;
    int        n_acc_rd;
    int        n_acc_wr;
    int        n_wb_wr;
    int        n_rval;
    int        n_checked;
    int        n_busy;

    assign mm_req = use_master ? m_req  : d_req;
    assign wreq   = use_master ? m_wreq : d_wreq;
    assign rreq   = use_master ? m_rreq : d_rreq;

    mmv_subsys_top u_dut (
        .clk    (clk),
        .reset  (reset),
        .mm_req (mm_req),
        .wreq   (wreq),
        .rreq   (rreq),
        .busy   (busy),
        .rdat   (rdat),
        .rval   (rval)
    );

    mmv_master_model #(.N_REQ(N_RANDOM)) u_master (
        .clk         (clk),
        .reset       (reset),
        .start       (m_start),
        .busy        (busy),
        .rval        (rval),
        .mm_req      (m_req),
        .wreq        (m_wreq),
        .rreq        (m_rreq),
        .done        (m_done),
        .n_sent      (m_sent),
        .outstanding (m_outstanding)
    );

    always #50 clk = ~clk;                        // 100 ns period

    // ----------------------------------------------------------
    // Reference model and checks
    // ----------------------------------------------------------
    function automatic mm_data_t ref_word(input mm_addr_t a);
        return shadow[a];                         // Latest accepted write
    endfunction

    function automatic mm_data_t fill_word(input mm_addr_t a);
        return {a, 6'h2A, ~a, 6'h15};
    endfunction

    task automatic fail_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Acceptance monitor and read compare, sampled on the rising edge
    always @(posedge clk) begin
        rd_entry_t ent;
        if (!reset) begin
            if (busy) n_busy++;
            if (u_dut.wb_s2m.ack && u_dut.wb_m2s.we) n_wb_wr++;   // Write done in memory
            if (rval) begin
                n_rval++;
                if (rd_q.size() == 0) begin
                    fail_run("rval arrived with no read outstanding");
                end else begin
                    ent = rd_q.pop_front();
                    if (ent.known) begin
                        check_value(rdat, ent.exp, $sformatf("read of 0x%0h", ent.addr));
                        n_checked++;
                    end
                end
            end
            if ((wreq || rreq) && !busy) begin
                if (wreq) begin
                    shadow[mm_req.addr]  = mm_req.wdat;
                    written[mm_req.addr] = 1'b1;
                    n_acc_wr++;
                end else begin
                    ent = '{addr: mm_req.addr, exp: ref_word(mm_req.addr),
                            known: written[mm_req.addr]};
                    rd_q.push_back(ent);
                    n_acc_rd++;
                end
            end
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == TIMEOUT_CYCLES)
            fail_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    // ----------------------------------------------------------
    // Directed stimulus helpers
    // ----------------------------------------------------------
    task automatic issue_req(input logic we, input mm_addr_t a, input mm_data_t d);
        @(negedge clk);
        d_req  = '{we: we, addr: a, wdat: d};
        d_wreq = we;
        d_rreq = ~we;
        while (busy) @(negedge clk);              // Held until the bridge has room
    endtask

    task automatic idle_inputs();
        @(negedge clk);
        d_wreq = 1'b0;
        d_rreq = 1'b0;
    endtask

    task automatic drain_reads();
        while (rd_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        int busy_mark;
        clk        = 1'b0;
        reset      = 1'b1;
        d_req      = '0;
        d_wreq     = 1'b0;
        d_rreq     = 1'b0;
        use_master = 1'b0;
        m_start    = 1'b0;
        cycle_cnt  = 0;
        n_acc_rd   = 0;
        n_acc_wr   = 0;
        n_wb_wr    = 0;
        n_rval     = 0;
        n_checked  = 0;
        n_busy     = 0;
        for (int i = 0; i < `MMV_MEM_DEPTH; i++) begin
            shadow[i]  = '0;
            written[i] = 1'b0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // Quiet outputs before any request
        repeat (3) begin
            @(negedge clk);
            check_value(32'(busy), 32'd0, "busy after reset");
            check_value(32'(rval), 32'd0, "rval after reset");
        end

        // Write then read back one word
        issue_req(1'b1, 10'h0A5, 32'hC0DE_1234);
        issue_req(1'b0, 10'h0A5, '0);
        idle_inputs();
        drain_reads();
        check_value(32'(n_checked), 32'd1, "checked reads after write/read pair");

        // Back-to-back traffic, skid buffer fills
        busy_mark = n_busy;
        issue_req(1'b1, 10'h155, 32'h1111_AAAA);
        issue_req(1'b1, 10'h155, 32'h2222_BBBB);  // Second write must win
        issue_req(1'b0, 10'h155, '0);
        for (int i = 0; i < 8; i++) begin
            issue_req(1'b1, mm_addr_t'(10'h300 + i), fill_word(mm_addr_t'(10'h300 + i)));
        end
        for (int i = 0; i < 8; i++) begin
            issue_req(1'b0, mm_addr_t'(10'h300 + i), '0);
        end
        idle_inputs();
        drain_reads();
        if (n_busy == busy_mark) fail_run("busy never rose during back-to-back requests");
        check_value(32'(n_wb_wr), 32'd11, "memory write cycles after directed phases");
        check_value(32'(n_checked), 32'd10, "checked reads after directed phases");

        // Random mixed traffic from the master
        @(negedge clk);
        use_master = 1'b1;
        m_start    = 1'b1;
        while (!m_done) @(negedge clk);
        drain_reads();
        repeat (2 * (`MMV_MAX_WAIT + 3)) @(negedge clk);   // Last write lands, no stray rval

        check_value(32'(n_wb_wr), 32'(n_acc_wr), "memory write cycles against accepted writes");
        check_value(32'(n_rval), 32'(n_acc_rd), "rval pulses against accepted reads");
        check_value(32'(m_outstanding), 32'd0, "master outstanding reads at end");
        if (n_checked <= 10) begin
            fail_run("random traffic produced no checked reads");
        end else begin
            $display("Reads checked: %0d, master requests: %0d, cycles: %0d",
                     n_checked, m_sent, cycle_cnt);
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule : tb_mmv_subsys

`default_nettype wire

// ==== filelist.f ====
+incdir+source
source/mmv_pkg.sv
source/mmv_wb_bridge.sv
source/wb_sram.sv
source/mmv_subsys_top.sv
bench/mmv_master_model.sv
bench/tb_mmv_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mmv_subsys \
    -f filelist.f \
    -o tb_mmv_subsys
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_mmv_subsys 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== source/mmv_defs.svh ====
`ifndef MMV_DEFS_SVH
`define MMV_DEFS_SVH

// ----------------------------------------------------------
// Subsystem widths
// ----------------------------------------------------------

// Word address, one address per 32-bit word
`define MMV_AWIDTH 10

// Data word
`define MMV_DWIDTH 32

// ----------------------------------------------------------
// Memory geometry and timing
// ----------------------------------------------------------

// Words in the on-chip memory, full address space
`define MMV_MEM_DEPTH (1 << `MMV_AWIDTH)

// Upper bound on wait states before ack
// Ack arrives 1 .. 1+MMV_MAX_WAIT cycles after stb rises
// Must stay at least 1, the wait counter needs a bit
`define MMV_MAX_WAIT 3

`endif

// ==== source/mmv_pkg.sv ====
`default_nettype none

`include "mmv_defs.svh"

package mmv_pkg;

    // ----------------------------------------------------------
    // Scalar types
    // ----------------------------------------------------------
    typedef logic [`MMV_AWIDTH-1:0] mm_addr_t;  // Word address
    typedef logic [`MMV_DWIDTH-1:0] mm_data_t;  // Data word

    // ----------------------------------------------------------
    // MemoryMapped request, 43 bits
    // ----------------------------------------------------------
    typedef struct packed {
        logic     we;     // Write when set, read otherwise
        mm_addr_t addr;   // Target word
        mm_data_t wdat;   // Write payload, don't care on reads
    } mm_req_t;

    // Wishbone classic, bridge to memory
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        mm_addr_t adr;
        mm_data_t dat;
    } wb_m2s_t;

    // Wishbone classic, memory to bridge
    typedef struct packed {
        logic     ack;
        mm_data_t dat;    // Valid with ack on reads
    } wb_s2m_t;

    // Bridge FSM
    typedef enum logic [1:0] {
        IDLE,             // Nothing on the bus
        BUS,              // Cycle open, waiting for ack
        RESP              // One cycle gap, rval goes out here
    } bridge_state_t;

endpackage : mmv_pkg

`default_nettype wire

// ==== source/mmv_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmv_subsys_top (
    input  wire                    clk,
    input  wire                    reset,
    // MemoryMapped target port
    input  wire mmv_pkg::mm_req_t  mm_req,
    input  wire                    wreq,
    input  wire                    rreq,
    output logic                   busy,
    output mmv_pkg::mm_data_t      rdat,
    output logic                   rval
);
    import mmv_pkg::*;

    // ----------------------------------------------------------
    // Internal Wishbone link
    // ----------------------------------------------------------
    wb_m2s_t wb_m2s;      // Bridge to memory
    wb_s2m_t wb_s2m;      // Memory to bridge

    // Request conversion, skid buffer, in-order read return
    mmv_wb_bridge u_bridge (
        .clk    (clk),
        .reset  (reset),
        .mm_req (mm_req),
        .wreq   (wreq),
        .rreq   (rreq),
        .busy   (busy),
        .rdat   (rdat),
        .rval   (rval),
        .wb_out (wb_m2s),
        .wb_in  (wb_s2m)
    );

    // Word memory with random wait states
    wb_sram u_sram (
        .clk    (clk),
        .reset  (reset),
        .wb_in  (wb_m2s),
        .wb_out (wb_s2m)
    );

endmodule : mmv_subsys_top

`default_nettype wire

// ==== source/mmv_wb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmv_wb_bridge (
    input  wire                    clk,
    input  wire                    reset,
    // MemoryMapped side
    input  wire mmv_pkg::mm_req_t  mm_req,
    input  wire                    wreq,
    input  wire                    rreq,
    output logic                   busy,
    output mmv_pkg::mm_data_t      rdat,
    output logic                   rval,
    // Wishbone classic side
    output mmv_pkg::wb_m2s_t       wb_out,
    input  wire mmv_pkg::wb_s2m_t  wb_in
);
    import mmv_pkg::*;

    // ----------------------------------------------------------
    // State
    // ----------------------------------------------------------
    bridge_state_t state;
    mm_req_t       act;         // Request on the bus, or next one while in RESP
    logic          act_vld;     // act holds a waiting request, meaningful in RESP
    mm_req_t       skid;        // One entry behind act
    logic          skid_vld;
    logic [2:0]    rd_open;     // Reads accepted, rval not yet given

    logic          in_bus;
    logic          done;        // Ack seen on the open cycle
    logic          acc;         // Request taken this edge
    mm_req_t       new_req;
    logic          act_from_skid;
    logic          act_from_in;
    logic          skid_load;

    // ----------------------------------------------------------
    // Accept and routing decisions
    // ----------------------------------------------------------
    always_comb begin
        in_bus  = (state == BUS);
        done    = in_bus & wb_in.ack;
        busy    = skid_vld & ~done;           // Full skid frees up on ack
        acc     = (wreq | rreq) & ~busy;
        new_req = '{we: wreq, addr: mm_req.addr, wdat: mm_req.wdat};

        // Skid moves up as soon as the open cycle completes
        act_from_skid = done & skid_vld;

        // Input goes straight to act when nothing else is queued
        act_from_in = acc & ((state == IDLE)
                           | (done & ~skid_vld)
                           | ((state == RESP) & ~act_vld));

        skid_load = acc & ~act_from_in;       // Otherwise it waits behind act
    end

    // ----------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            act_vld  <= 1'b0;
            skid_vld <= 1'b0;
            rval     <= 1'b0;
            rd_open  <= '0;
        end else begin
            rval <= done & ~act.we;           // Single pulse, reads only

            // At most three reads in flight, act, skid and the one in RESP
            rd_open <= rd_open + 3'(acc & rreq) - 3'(rval);

            case (state)
                IDLE: begin
                    if (acc) state <= BUS;
                end
                BUS: begin
                    if (wb_in.ack) begin
                        state   <= RESP;
                        act_vld <= skid_vld | acc;
                    end
                end
                RESP: begin
                    // cyc stays low here, memory sees a fresh cycle next
                    if (act_vld | acc) state <= BUS;
                    else               state <= IDLE;
                    act_vld <= 1'b0;
                end
                default: state <= IDLE;
            endcase

            if (skid_load)          skid_vld <= 1'b1;
            else if (act_from_skid) skid_vld <= 1'b0;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (act_from_skid)    act <= skid;
        else if (act_from_in) act <= new_req;

        if (skid_load) skid <= new_req;

        if (done) rdat <= wb_in.dat;          // Ack data, shown with rval
    end

    // ----------------------------------------------------------
    // Wishbone drive
    // ----------------------------------------------------------
    assign wb_out = '{cyc: in_bus,
                      stb: in_bus,
                      we:  act.we,
                      adr: act.addr,
                      dat: act.wdat};

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------

    // Open cycle holds until the memory answers
    a_stb_hold : assert property (@(posedge clk) disable iff (reset)
        wb_out.stb && !wb_in.ack |=>
            wb_out.stb && $stable(wb_out.adr) && $stable(wb_out.we))
        else $error("stb or adr changed before ack");

    // rval only after an ack, and only for a read still unanswered
    a_rval_src : assert property (@(posedge clk) disable iff (reset)
        rval |-> $past(wb_in.ack) && rd_open != '0)
        else $error("rval without a completed read");

    // Master never asks for both
    a_req_excl : assert property (@(posedge clk) disable iff (reset)
        !(wreq && rreq))
        else $error("wreq and rreq high together");

endmodule : mmv_wb_bridge

`default_nettype wire

// ==== source/wb_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmv_defs.svh"

module wb_sram (
    input  wire                    clk,
    input  wire                    reset,
    input  wire mmv_pkg::wb_m2s_t  wb_in,
    output mmv_pkg::wb_s2m_t       wb_out
);
    import mmv_pkg::*;

    localparam int CNT_W = $clog2(`MMV_MAX_WAIT + 1);
    localparam logic [7:0] LFSR_SEED = 8'h5A;   // Any non-zero value

    // ----------------------------------------------------------
    // Storage, no reset on contents
    // ----------------------------------------------------------
    mm_data_t mem [`MMV_MEM_DEPTH];
    mm_data_t rd_q;                  // Registered read word

    logic             req;           // Valid Wishbone strobe
    logic             ack_q;
    logic             ack_set;       // Ack goes out next cycle
    logic             active;        // Wait count loaded for this cycle
    logic [CNT_W-1:0] cnt;           // Waits still to go
    logic [CNT_W-1:0] wait_new;      // Draw for a new cycle
    logic [7:0]       lfsr;
    logic             lfsr_fb;

    // ----------------------------------------------------------
    // Wait state draw
    // ----------------------------------------------------------
    always_comb begin
        req      = wb_in.cyc & wb_in.stb;
        lfsr_fb  = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];   // x^8+x^6+x^5+x^4+1
        wait_new = CNT_W'(lfsr % (`MMV_MAX_WAIT + 1));

        // No new ack while the current one is still out
        ack_set = req & ~ack_q & (active ? (cnt == '0) : (wait_new == '0));
    end

    // Handshake control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q  <= 1'b0;
            active <= 1'b0;
            cnt    <= '0;
            lfsr   <= LFSR_SEED;
        end else begin
            ack_q <= ack_set;

            if (!req) begin
                active <= 1'b0;             // Cycle dropped
            end else if (!ack_q) begin
                if (!active) begin
                    // Fresh stb, load the count
                    if (wait_new != '0) begin
                        active <= 1'b1;
                        cnt    <= wait_new - 1'b1;
                    end
                end else if (cnt == '0) begin
                    active <= 1'b0;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end

            if (ack_q) lfsr <= {lfsr[6:0], lfsr_fb};   // New draw per access
        end
    end

    // ----------------------------------------------------------
    // Array access, on the edge that raises ack
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ack_set) begin
            if (wb_in.we) mem[wb_in.adr] <= wb_in.dat;
            rd_q <= mem[wb_in.adr];         // Old word on writes, unused
        end
    end

    assign wb_out = '{ack: ack_q, dat: rd_q};

    // Ack only inside an open cycle from the bridge
    a_ack_in_cyc : assert property (@(posedge clk) disable iff (reset)
        wb_out.ack |-> wb_in.cyc && wb_in.stb)
        else $error("ack outside of cyc/stb");

endmodule : wb_sram

`default_nettype wire
